// ==== nabp_geom_pkg.sv ====
package nabp_geom_pkg;

    // widths of the datapath quantities
    localparam int SAMPLE_W    = 12;
    localparam int PIX_SUM_W   = 20;
    localparam int SHIFT_W     = 8;
    localparam int MAP_ACCU_W  = 16;

    // fractional bits of the mapper accumulator
    localparam int MAP_FRAC = 4;

    // one projection sample
    typedef logic [SAMPLE_W-1:0] sample_t;

    // accumulated pixel value, wraps at full width
    typedef logic [PIX_SUM_W-1:0] pixel_sum_t;

    // rotation offset applied to a line on shift out
    typedef logic [SHIFT_W-1:0] shift_base_t;

    // mapper accumulator and step, fixed point
    typedef logic [MAP_ACCU_W-1:0] map_accu_t;

endpackage

// ==== nabp_ctrl_pkg.sv ====
package nabp_ctrl_pkg;

    // per-iteration sequence of the state controller
    typedef enum logic [1:0] {
        ready_s,
        fill_s,
        fill_done_s,
        shift_s
    } sc_state_t;

    // register map, byte offsets
    localparam logic [7:0] REG_CTRL     = 8'h00;
    localparam logic [7:0] REG_SH_BASE  = 8'h04;
    localparam logic [7:0] REG_MP_INIT  = 8'h08;
    localparam logic [7:0] REG_MP_BASE  = 8'h0C;
    localparam logic [7:0] REG_ITR      = 8'h10;
    localparam logic [7:0] REG_STATUS   = 8'h14;
    localparam logic [7:0] REG_PIX_BASE = 8'h40;

    // only response ever returned
    localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

// ==== nabp_axil_regs.sv ====
`timescale 1ns/1ps

module nabp_axil_regs #(
    parameter int LINE_LEN = 8
) (
    input  logic                                       clk,
    input  logic                                       reset_n,
    input  logic [7:0]                                 awaddr,
    input  logic                                       awvalid,
    output logic                                       awready,
    input  logic [31:0]                                wdata,
    input  logic                                       wvalid,
    output logic                                       wready,
    output logic [1:0]                                 bresp,
    output logic                                       bvalid,
    input  logic                                       bready,
    input  logic [7:0]                                 araddr,
    input  logic                                       arvalid,
    output logic                                       arready,
    output logic [31:0]                                rdata,
    output logic [1:0]                                 rresp,
    output logic                                       rvalid,
    input  logic                                       rready,
    input  logic                                       busy,
    input  logic [7:0]                                 itr_done,
    input  nabp_geom_pkg::pixel_sum_t [LINE_LEN-1:0]   pix_sums,
    output nabp_geom_pkg::shift_base_t                 sh_base,
    output nabp_geom_pkg::map_accu_t                   mp_init,
    output nabp_geom_pkg::map_accu_t                   mp_base,
    output logic                                       itr_add,
    output logic [7:0]                                 itr_count_wr,
    output logic                                       clear_pulse
);

    import nabp_geom_pkg::*;
    import nabp_ctrl_pkg::*;

    localparam int IDX_W = $clog2(LINE_LEN);

    logic        aw_held;
    logic        w_held;
    logic [7:0]  aw_addr_q;
    logic [31:0] w_data_q;
    logic        aw_hs;
    logic        w_hs;
    logic        wr_go;
    logic [7:0]  wr_addr;
    logic [31:0] wr_data;
    logic [7:0]  pix_off;
    logic        pix_hit;
    logic [31:0] rd_mux;

    // new address or data only when nothing is latched and no response pending
    assign awready = !aw_held && !bvalid;
    assign wready  = !w_held && !bvalid;
    assign arready = !rvalid;
    assign bresp   = RESP_OKAY;
    assign rresp   = RESP_OKAY;

    assign aw_hs   = awvalid && awready;
    assign w_hs    = wvalid && wready;
    // commit as soon as both halves are present, latched or arriving
    assign wr_go   = (aw_held || aw_hs) && (w_held || w_hs);
    assign wr_addr = aw_held ? aw_addr_q : awaddr;
    assign wr_data = w_held ? w_data_q : wdata;

    always_ff @(posedge clk)
    begin
        if (aw_hs)
            aw_addr_q <= awaddr;
        if (w_hs)
            w_data_q <= wdata;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            aw_held      <= 1'b0;
            w_held       <= 1'b0;
            bvalid       <= 1'b0;
            sh_base      <= '0;
            mp_init      <= '0;
            mp_base      <= '0;
            itr_add      <= 1'b0;
            itr_count_wr <= '0;
            clear_pulse  <= 1'b0;
        end
        else
        begin
            itr_add     <= 1'b0;
            clear_pulse <= 1'b0;
            if (bvalid && bready)
                bvalid <= 1'b0;
            if (wr_go)
            begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                bvalid  <= 1'b1;
                case (wr_addr)
                    REG_CTRL:    clear_pulse <= wr_data[0];
                    REG_SH_BASE: sh_base <= shift_base_t'(wr_data);
                    REG_MP_INIT: mp_init <= map_accu_t'(wr_data);
                    REG_MP_BASE: mp_base <= map_accu_t'(wr_data);
                    REG_ITR:
                    begin
                        itr_add      <= 1'b1;
                        itr_count_wr <= wr_data[7:0];
                    end
                    default: ;
                endcase
            end
            else
            begin
                if (aw_hs)
                    aw_held <= 1'b1;
                if (w_hs)
                    w_held <= 1'b1;
            end
        end
    end

    // pixel window, 4 bytes per pixel
    assign pix_off = araddr - REG_PIX_BASE;
    assign pix_hit = (araddr >= REG_PIX_BASE) && (pix_off[7:2] < LINE_LEN);

    always_comb
    begin
        rd_mux = '0;
        if (pix_hit)
            rd_mux = 32'(pix_sums[pix_off[IDX_W+1:2]]);
        else
            case (araddr)
                REG_SH_BASE: rd_mux = 32'(sh_base);
                REG_MP_INIT: rd_mux = 32'(mp_init);
                REG_MP_BASE: rd_mux = 32'(mp_base);
                REG_STATUS:  rd_mux = {16'b0, itr_done, 7'b0, busy};
                default:     rd_mux = '0;
            endcase
    end

    always_ff @(posedge clk)
    begin
        if (arvalid && arready)
            rdata <= rd_mux;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            rvalid <= 1'b0;
        else if (arvalid && arready)
            rvalid <= 1'b1;
        else if (rready)
            rvalid <= 1'b0;
    end

    // responses hold until the host takes them
    a_resp_hold: assert property (@(posedge clk) disable iff (!reset_n)
        (bvalid && !bready |=> bvalid) and (rvalid && !rready |=> rvalid));

endmodule

// ==== nabp_swap_control.sv ====
`timescale 1ns/1ps

module nabp_swap_control (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       itr_add,
    input  logic [7:0] itr_count_wr,
    input  logic       sw_next_itr,
    input  logic       sw_swap,
    input  logic       sw_pe_en,
    input  logic       sh_shift_done,
    output logic       sw_next_itr_ack,
    output logic       sw_swap_ack,
    output logic       bank_sel,
    output logic       busy,
    output logic [7:0] itr_done
);

    logic [7:0] armed_cnt;
    logic [7:0] add_cnt;
    logic       grant;
    logic       active;

    // one grant per request, only while iterations are armed
    assign grant   = sw_next_itr && !sw_next_itr_ack && (armed_cnt != 8'd0);
    assign add_cnt = itr_add ? itr_count_wr : 8'd0;
    assign busy    = (armed_cnt != 8'd0) || active;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            armed_cnt       <= '0;
            active          <= 1'b0;
            itr_done        <= '0;
            sw_next_itr_ack <= 1'b0;
            sw_swap_ack     <= 1'b0;
            bank_sel        <= 1'b0;
        end
        else
        begin
            sw_next_itr_ack <= grant;
            sw_swap_ack     <= sw_swap && !sw_swap_ack;
            armed_cnt       <= armed_cnt + add_cnt - 8'(grant);
            // filled bank becomes the shift bank
            if (sw_swap_ack)
                bank_sel <= !bank_sel;
            if (grant)
                active <= 1'b1;
            else if (sw_pe_en && sh_shift_done)
                active <= 1'b0;
            if (sw_pe_en && sh_shift_done)
                itr_done <= itr_done + 8'd1;
        end
    end

    a_ack_has_req: assert property (@(posedge clk) disable iff (!reset_n)
        (sw_next_itr_ack |-> sw_next_itr) and (sw_swap_ack |-> sw_swap));

endmodule

// ==== nabp_state_control.sv ====
`timescale 1ns/1ps

module nabp_state_control (
    input  logic                        clk,
    input  logic                        reset_n,
    input  nabp_geom_pkg::shift_base_t  sw_sh_accu_base,
    input  nabp_geom_pkg::map_accu_t    sw_mp_accu_init,
    input  nabp_geom_pkg::map_accu_t    sw_mp_accu_base,
    input  logic                        sw_swap_ack,
    input  logic                        sw_next_itr_ack,
    input  logic                        sh_fill_done,
    input  logic                        sh_shift_done,
    output logic                        sw_swap,
    output logic                        sw_next_itr,
    output logic                        sw_pe_en,
    output logic                        sh_fill_kick,
    output logic                        sh_shift_kick,
    output nabp_geom_pkg::shift_base_t  sh_accu_base,
    output nabp_geom_pkg::map_accu_t    mp_accu_init,
    output nabp_geom_pkg::map_accu_t    mp_accu_base
);

    import nabp_ctrl_pkg::*;

    sc_state_t state;
    sc_state_t next_state;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= ready_s;
        else
            state <= next_state;
    end

    // parameters frozen for the whole iteration once it leaves ready
    always_ff @(posedge clk)
    begin
        if (state == ready_s)
        begin
            sh_accu_base <= sw_sh_accu_base;
            mp_accu_init <= sw_mp_accu_init;
            mp_accu_base <= sw_mp_accu_base;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            ready_s:     if (sw_next_itr_ack) next_state = fill_s;
            fill_s:      if (sh_fill_done) next_state = fill_done_s;
            fill_done_s: if (sw_swap_ack) next_state = shift_s;
            shift_s:     if (sh_shift_done) next_state = ready_s;
            default:     next_state = ready_s;
        endcase
    end

    assign sw_next_itr   = (state == ready_s);
    assign sw_swap       = (state == fill_done_s);
    assign sw_pe_en      = (state == shift_s);
    // kicks fire on the transition into their state
    assign sh_fill_kick  = (next_state != state) && (next_state == fill_s);
    assign sh_shift_kick = (next_state != state) && (next_state == shift_s);

    // shifter done pulses only arrive while their state waits for them
    a_done_in_state: assert property (@(posedge clk) disable iff (!reset_n)
        (sh_fill_done |-> state == fill_s) and (sh_shift_done |-> state == shift_s));

endmodule

// ==== nabp_shifter.sv ====
`timescale 1ns/1ps

module nabp_shifter #(
    parameter int LINE_LEN = 8
) (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        sample_valid,
    input  nabp_geom_pkg::sample_t      sample_data,
    output logic                        sample_ready,
    input  logic                        sh_fill_kick,
    input  logic                        sh_shift_kick,
    input  nabp_geom_pkg::shift_base_t  sh_accu_base,
    input  logic                        bank_sel,
    output logic                        sh_fill_done,
    output logic                        sh_shift_done,
    output nabp_geom_pkg::sample_t      pe_sample
);

    import nabp_geom_pkg::*;

    localparam int IDX_W = $clog2(LINE_LEN);
    localparam logic [IDX_W-1:0] LAST = IDX_W'(LINE_LEN - 1);

    sample_t          line_buf [0:1][0:LINE_LEN-1];
    logic             filling;
    logic             shifting;
    logic [IDX_W-1:0] step;
    logic [IDX_W-1:0] rd_idx;
    logic             accept;

    assign sample_ready = filling;
    assign accept       = filling && sample_valid;

    // fill goes to the idle bank while the other one may be read
    always_ff @(posedge clk)
    begin
        if (accept)
            line_buf[!bank_sel][step] <= sample_data;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            filling      <= 1'b0;
            shifting     <= 1'b0;
            step         <= '0;
            sh_fill_done <= 1'b0;
        end
        else
        begin
            sh_fill_done <= accept && (step == LAST);
            if (sh_fill_kick || sh_shift_kick)
                step <= '0;
            else if (accept || shifting)
                step <= step + 1'b1;
            if (sh_fill_kick)
                filling <= 1'b1;
            else if (accept && (step == LAST))
                filling <= 1'b0;
            if (sh_shift_kick)
                shifting <= 1'b1;
            else if (sh_shift_done)
                shifting <= 1'b0;
        end
    end

    // rotation wraps on the line length
    assign rd_idx        = step + sh_accu_base[IDX_W-1:0];
    assign pe_sample     = line_buf[bank_sel][rd_idx];
    assign sh_shift_done = shifting && (step == LAST);

endmodule

// ==== nabp_backproject.sv ====
`timescale 1ns/1ps

module nabp_backproject #(
    parameter int LINE_LEN = 8
) (
    input  logic                                       clk,
    input  logic                                       reset_n,
    input  logic                                       sw_pe_en,
    input  nabp_geom_pkg::sample_t                     pe_sample,
    input  nabp_geom_pkg::map_accu_t                   mp_accu_init,
    input  nabp_geom_pkg::map_accu_t                   mp_accu_base,
    input  logic                                       clear_pulse,
    output nabp_geom_pkg::pixel_sum_t [LINE_LEN-1:0]   pix_sums
);

    import nabp_geom_pkg::*;

    localparam int IDX_W = $clog2(LINE_LEN);

    map_accu_t        accu_q;
    map_accu_t        cur_accu;
    logic             pe_en_q;
    logic             first;
    logic [IDX_W-1:0] pix_idx;

    // first step of a line uses the initial value directly
    assign first    = sw_pe_en && !pe_en_q;
    assign cur_accu = first ? mp_accu_init : accu_q;
    // integer part of the accumulator, wrapped onto the row
    assign pix_idx  = cur_accu[MAP_FRAC +: IDX_W];

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            pe_en_q <= 1'b0;
        else
            pe_en_q <= sw_pe_en;
    end

    always_ff @(posedge clk)
    begin
        if (sw_pe_en)
            accu_q <= cur_accu + mp_accu_base;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n || clear_pulse)
            pix_sums <= '0;
        else if (sw_pe_en)
            pix_sums[pix_idx] <= pix_sums[pix_idx] + pixel_sum_t'(pe_sample);
    end

endmodule

// ==== nabp_core.sv ====
`timescale 1ns/1ps

module nabp_core #(
    parameter int LINE_LEN = 8
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic [7:0]              awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [31:0]             wdata,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [7:0]              araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [31:0]             rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    input  logic                    sample_valid,
    input  nabp_geom_pkg::sample_t  sample_data,
    output logic                    sample_ready
);

    import nabp_geom_pkg::*;

    shift_base_t                sh_base, sh_accu_base;
    map_accu_t                  mp_init, mp_base, mp_accu_init, mp_accu_base;
    pixel_sum_t [LINE_LEN-1:0]  pix_sums;
    sample_t                    pe_sample;
    logic [7:0]                 itr_count_wr, itr_done;
    logic                       itr_add, clear_pulse, busy, bank_sel;
    logic                       sw_next_itr, sw_next_itr_ack, sw_swap, sw_swap_ack, sw_pe_en;
    logic                       sh_fill_kick, sh_shift_kick, sh_fill_done, sh_shift_done;

    // decode
    nabp_axil_regs #(.LINE_LEN(LINE_LEN)) u_regs (.*);

    // execute
    nabp_swap_control u_swap (.*);

    nabp_state_control u_state (
        .sw_sh_accu_base (sh_base),
        .sw_mp_accu_init (mp_init),
        .sw_mp_accu_base (mp_base),
        .*
    );

    nabp_shifter #(.LINE_LEN(LINE_LEN)) u_shifter (.*);

    // result
    nabp_backproject #(.LINE_LEN(LINE_LEN)) u_backproject (.*);

endmodule

// ==== tb_nabp_core.sv ====
`timescale 1ns/1ps

module tb_nabp_core;

    import nabp_geom_pkg::*;
    import nabp_ctrl_pkg::*;

    localparam int LINE_LEN = 8;
    localparam int TIMEOUT  = 200;

    logic        clk;
    logic        reset_n;
    logic [7:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        sample_valid;
    sample_t     sample_data;
    logic        sample_ready;

    int          seed;
    int          fd;
    int          errors;
    int          test_base;
    int          pass_cnt;
    int          fail_cnt;
    sample_t     line_q [LINE_LEN];
    pixel_sum_t  exp_q [LINE_LEN];

    nabp_core #(.LINE_LEN(LINE_LEN)) u_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task report_timeout(input string what);
        $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
        errors++;
    endtask

    task check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("Error: %s got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task check_sum(input int idx, input pixel_sum_t got, input pixel_sum_t exp);
        if (got !== exp)
        begin
            $display("Error: pix_sums[%0d] got 0x%05h expected 0x%05h", idx, got, exp);
            errors++;
        end
    endtask

    task axi_write(input logic [7:0] addr, input logic [31:0] data);
        int t;
        bit aw_go;
        bit w_go;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        t = 0;
        // AW and W may be taken in different cycles
        while ((awvalid || wvalid) && t < TIMEOUT)
        begin
            aw_go = awvalid && awready;
            w_go  = wvalid && wready;
            @(negedge clk);
            if (aw_go)
                awvalid = 1'b0;
            if (w_go)
                wvalid = 1'b0;
            t++;
        end
        if (awvalid || wvalid)
        begin
            report_timeout("write address/data transfer");
            awvalid = 1'b0;
            wvalid  = 1'b0;
        end
        else
        begin
            t = 0;
            while (!bvalid && t < TIMEOUT)
            begin
                @(negedge clk);
                t++;
            end
            if (!bvalid)
                report_timeout("write response");
            else
            begin
                check_word("bresp", 32'(bresp), 32'(RESP_OKAY));
                // bready is held high, response taken at next rising edge
                @(negedge clk);
            end
        end
    endtask

    task axi_read(input logic [7:0] addr, output logic [31:0] data);
        int t;
        bit ar_go;
        data = '0;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        t = 0;
        while (arvalid && t < TIMEOUT)
        begin
            ar_go = arready;
            @(negedge clk);
            if (ar_go)
                arvalid = 1'b0;
            t++;
        end
        if (arvalid)
        begin
            report_timeout("read address transfer");
            arvalid = 1'b0;
        end
        else
        begin
            t = 0;
            while (!rvalid && t < TIMEOUT)
            begin
                @(negedge clk);
                t++;
            end
            if (!rvalid)
                report_timeout("read data");
            else
            begin
                data = rdata;
                check_word("rresp", 32'(rresp), 32'(RESP_OKAY));
                @(negedge clk);
            end
        end
    endtask

    // one line from line_q, optional random gaps in valid
    task feed_line(input logic [31:0] gaps);
        int k;
        int t;
        k = 0;
        t = 0;
        while (k < LINE_LEN && t < TIMEOUT)
        begin
            @(negedge clk);
            sample_data  = line_q[k];
            sample_valid = (gaps == 0) || (($random(seed) & 3) != 0);
            // ready is registered, so this is the handshake of the next edge
            if (sample_valid && sample_ready)
                k++;
            t++;
        end
        if (k < LINE_LEN)
            report_timeout("sample line acceptance");
        @(negedge clk);
        sample_valid = 1'b0;
    endtask

    task wait_idle();
        logic [31:0] st;
        int t;
        st = 32'h1;
        t = 0;
        while (st[0] && t < TIMEOUT)
        begin
            axi_read(REG_STATUS, st);
            t++;
        end
        if (st[0])
            report_timeout("busy falling");
    endtask

    task check_pixels();
        logic [31:0] word;
        wait_idle();
        for (int i = 0; i < LINE_LEN; i++)
        begin
            axi_read(REG_PIX_BASE + 8'(i * 4), word);
            check_sum(i, pixel_sum_t'(word), exp_q[i]);
        end
    endtask

    task read_field(output logic [31:0] v);
        int code;
        code = $fscanf(fd, "%h", v);
        if (code != 1)
        begin
            $display("Stimulus file ended in the middle of a record");
            errors++;
            v = '0;
        end
    endtask

    task end_test(input logic [31:0] id);
        if (errors == test_base)
        begin
            $display("test %0d passed", id);
            pass_cnt++;
        end
        else
        begin
            $display("test %0d failed with %0d errors", id, errors - test_base);
            fail_cnt++;
        end
        test_base = errors;
    endtask

    // opcodes: 1 write, 2 read and compare, 3 parameters, 4 arm,
    // 5 feed line, 6 compare pixel sums, 7 end of test
    task run_record(input logic [31:0] op);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] word;
        case (op)
            32'h1:
            begin
                read_field(a);
                read_field(b);
                axi_write(a[7:0], b);
            end
            32'h2:
            begin
                read_field(a);
                read_field(b);
                axi_read(a[7:0], word);
                check_word($sformatf("rdata at 0x%02h", a[7:0]), word, b);
            end
            32'h3:
            begin
                read_field(a);
                read_field(b);
                read_field(c);
                axi_write(REG_SH_BASE, a);
                axi_write(REG_MP_INIT, b);
                axi_write(REG_MP_BASE, c);
            end
            32'h4:
            begin
                read_field(a);
                axi_write(REG_ITR, a);
            end
            32'h5:
            begin
                read_field(a);
                for (int i = 0; i < LINE_LEN; i++)
                begin
                    read_field(b);
                    line_q[i] = sample_t'(b);
                end
                feed_line(a);
            end
            32'h6:
            begin
                for (int i = 0; i < LINE_LEN; i++)
                begin
                    read_field(b);
                    exp_q[i] = pixel_sum_t'(b);
                end
                check_pixels();
            end
            32'h7:
            begin
                read_field(a);
                end_test(a);
            end
            default:
            begin
                $display("Unknown record type %0h in the stimulus file", op);
                errors++;
            end
        endcase
    endtask

    initial
    begin
        int code;
        bit running;
        logic [31:0] op;
        seed         = 32'h56ae;
        errors       = 0;
        test_base    = 0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        reset_n      = 1'b0;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wvalid       = 1'b0;
        bready       = 1'b1;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b1;
        sample_valid = 1'b0;
        sample_data  = '0;
        repeat (16) @(negedge clk);
        reset_n = 1'b1;

        fd = $fopen("nabp_stim.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file nabp_stim.txt");
            errors++;
        end
        else
        begin
            running = 1'b1;
            while (running)
            begin
                code = $fscanf(fd, "%h", op);
                if (code != 1)
                    running = 1'b0;
                else
                    run_record(op);
            end
            $fclose(fd);
        end

        $display("%0d tests passed, %0d tests failed, %0d errors", pass_cnt, fail_cnt, errors);
        if (errors == 0 && fail_cnt == 0 && pass_cnt > 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// ==== nabp_stim.txt ====
2 14 0
1 4 5
2 4 5
1 8 abcd
2 8 abcd
1 c 123
2 c 123
2 40 0
7 1
1 0 1
3 0 0 10
4 3
5 0 1 2 3 4 5 6 7 8
5 1 10 20 30 40 50 60 70 80
5 0 100 200 300 400 500 600 700 800
6 111 222 333 444 555 666 777 888
2 14 300
7 2
1 0 1
3 0 0 10
4 1
5 0 a1 b2 c3 d4 e5 f6 107 118
6 a1 b2 c3 d4 e5 f6 107 118
7 3
1 0 1
3 3 8 18
4 1
5 0 101 202 303 404 505 606 707 808
6 505 202 505 909 0 707 808 0
7 4
1 0 1
3 3 8 18
4 1
5 1 101 202 303 404 505 606 707 808
6 505 202 505 909 0 707 808 0
7 5
1 0 1
6 0 0 0 0 0 0 0 0
7 6

// ==== vlog.f ====
nabp_geom_pkg.sv
nabp_ctrl_pkg.sv
nabp_axil_regs.sv
nabp_swap_control.sv
nabp_state_control.sv
nabp_shifter.sv
nabp_backproject.sv
nabp_core.sv
tb_nabp_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tb_nabp_core -o sim_nabp

./obj_dir/sim_nabp | tee sim.log

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
grep -q "TB PASSED" sim.log
